// ==== rtl/rv_lite_pkg.sv ====
// rv_lite shared definitions
// widths, major opcodes, alu operations, access sizes and sequencer states
`default_nettype none

package rv_lite_pkg;

  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // values are the opcode field encodings, ir[6:0]
  typedef enum logic [6:0] {
    OP      = 7'b0110011,
    OP_IMM  = 7'b0010011,
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    ILLEGAL = 7'b0000000   // anything not in the kept subset
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_SLL   = 4'd2,
    ALU_SLT   = 4'd3,
    ALU_SLTU  = 4'd4,
    ALU_XOR   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_OR    = 4'd8,
    ALU_AND   = 4'd9,
    ALU_PASSB = 4'd10   // lui, operand b straight through
  } alu_op_t;

  // follows funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MS_BYTE = 2'd0,
    MS_HALF = 2'd1,
    MS_WORD = 2'd2
  } mem_size_t;

  // one instruction in flight
  typedef enum logic [1:0] {
    ST_FETCH = 2'd0,
    ST_EXEC  = 2'd1,
    ST_MEM   = 2'd2
  } state_t;

endpackage

`default_nettype wire

// ==== rtl/rv_lite_ctrl.sv ====
// rv_lite control unit
// fetch/exec/mem sequencer with pc and instruction register,
// operand and writeback select, next pc and bus requests
`default_nettype none

module rv_lite_ctrl
  import rv_lite_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic    clk,
  input  logic    xreset,
  output logic    o_imem_valid,
  output word_t   o_imem_addr,
  input  logic    i_imem_ready,
  input  word_t   i_imem_rdata,
  output logic    o_dmem_valid,
  output logic    o_dmem_we,
  output word_t   o_dmem_addr,
  input  logic    i_dmem_ready,
  output word_t   o_ir,
  input  opcode_t i_opcode,
  input  word_t   i_imm,
  input  word_t   i_rs1_data,
  input  word_t   i_rs2_data,
  input  word_t   i_alu_result,
  input  logic    i_branch_taken,
  input  word_t   i_load_data,
  output word_t   o_alu_a,
  output word_t   o_alu_b,
  output logic    o_rd_we,
  output word_t   o_rd_data
);

  state_t state;
  logic   run;        // low in the first cycle out of reset
  word_t  pc;
  word_t  ir;
  word_t  pc_plus4;
  word_t  pc_target;
  word_t  next_pc;
  logic   imem_hs;
  logic   dmem_hs;
  logic   is_mem;
  logic   is_link;

  assign imem_hs = o_imem_valid && i_imem_ready;
  assign dmem_hs = o_dmem_valid && i_dmem_ready;
  assign is_mem  = (i_opcode == LOAD) || (i_opcode == STORE);
  assign is_link = (i_opcode == JAL) || (i_opcode == JALR);

  assign o_imem_valid = run && (state == ST_FETCH);
  assign o_imem_addr  = pc;
  assign o_dmem_valid = (state == ST_MEM);
  assign o_dmem_we    = o_dmem_valid && (i_opcode == STORE);
  assign o_dmem_addr  = i_alu_result;   // rs1 + imm, ir and regs hold still in ST_MEM
  assign o_ir         = ir;

  // pc feeds auipc and jal, rs2 only for reg-reg ops and compares
  assign o_alu_a = (i_opcode == AUIPC || i_opcode == JAL) ? pc : i_rs1_data;
  assign o_alu_b = (i_opcode == OP || i_opcode == BRANCH) ? i_rs2_data : i_imm;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + i_imm;

  always_comb begin
    case (i_opcode)
      JAL:     next_pc = pc_target;
      JALR:    next_pc = {i_alu_result[XLEN-1:1], 1'b0};
      BRANCH:  next_pc = i_branch_taken ? pc_target : pc_plus4;
      default: next_pc = pc_plus4;   // illegal just steps over
    endcase
  end

  // writeback, exec for alu and jumps, mem handshake for loads
  always_comb begin
    case (state)
      ST_EXEC: o_rd_we = i_opcode inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR};
      ST_MEM:  o_rd_we = dmem_hs && (i_opcode == LOAD);
      default: o_rd_we = 1'b0;
    endcase
    if (is_link)
      o_rd_data = pc_plus4;
    else if (i_opcode == LOAD)
      o_rd_data = i_load_data;
    else
      o_rd_data = i_alu_result;
  end

  always_ff @(posedge clk) begin
    if (!xreset) begin
      state <= ST_FETCH;
      run   <= 1'b0;
      pc    <= RESET_PC;
    end else begin
      run <= 1'b1;
      case (state)
        ST_FETCH: if (imem_hs) state <= ST_EXEC;
        ST_EXEC: begin
          pc    <= next_pc;   // pc no longer needed once exec is done
          state <= is_mem ? ST_MEM : ST_FETCH;
        end
        ST_MEM:   if (dmem_hs) state <= ST_FETCH;
        default:  state <= ST_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (imem_hs)
      ir <= i_imem_rdata;
  end

endmodule

`default_nettype wire

// ==== rtl/rv_lite_decode.sv ====
// rv_lite instruction decoder
// opcode, alu operation, access size, register fields and immediate
`default_nettype none

module rv_lite_decode
  import rv_lite_pkg::*;
(
  input  word_t     i_ir,
  output opcode_t   o_opcode,
  output alu_op_t   o_alu_op,
  output mem_size_t o_size,
  output logic      o_load_unsigned,
  output logic [4:0] o_rs1_addr,
  output logic [4:0] o_rs2_addr,
  output logic [4:0] o_rd_addr,
  output word_t     o_imm
);

  logic [2:0] funct3;
  logic       funct7_5;   // sub / sra select

  assign funct3   = i_ir[14:12];
  assign funct7_5 = i_ir[30];

  assign o_rs1_addr = i_ir[19:15];
  assign o_rs2_addr = i_ir[24:20];
  assign o_rd_addr  = i_ir[11:7];

  assign o_load_unsigned = funct3[2];   // lbu, lhu
  assign o_size = (funct3[1:0] == 2'd0) ? MS_BYTE :
                  (funct3[1:0] == 2'd1) ? MS_HALF : MS_WORD;

  always_comb begin
    case (i_ir[6:0])
      OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE:
        o_opcode = opcode_t'(i_ir[6:0]);
      default:
        o_opcode = ILLEGAL;
    endcase
  end

  always_comb begin
    case (o_opcode)
      OP, OP_IMM: begin
        case (funct3)
          3'd0:    o_alu_op = (o_opcode == OP && funct7_5) ? ALU_SUB : ALU_ADD;
          3'd1:    o_alu_op = ALU_SLL;
          3'd2:    o_alu_op = ALU_SLT;
          3'd3:    o_alu_op = ALU_SLTU;
          3'd4:    o_alu_op = ALU_XOR;
          3'd5:    o_alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
          3'd6:    o_alu_op = ALU_OR;
          default: o_alu_op = ALU_AND;
        endcase
      end
      LUI:     o_alu_op = ALU_PASSB;
      BRANCH:  o_alu_op = ALU_SUB;   // compare, the taken flag is what counts
      default: o_alu_op = ALU_ADD;   // address add, auipc, jal, jalr
    endcase
  end

  // sign-extended immediate per format
  always_comb begin
    case (o_opcode)
      OP_IMM, JALR, LOAD:
        o_imm = {{20{i_ir[31]}}, i_ir[31:20]};
      STORE:
        o_imm = {{20{i_ir[31]}}, i_ir[31:25], i_ir[11:7]};
      BRANCH:
        o_imm = {{19{i_ir[31]}}, i_ir[31], i_ir[7], i_ir[30:25], i_ir[11:8], 1'b0};
      LUI, AUIPC:
        o_imm = {i_ir[31:12], 12'h000};
      JAL:
        o_imm = {{11{i_ir[31]}}, i_ir[31], i_ir[19:12], i_ir[20], i_ir[30:21], 1'b0};
      default:
        o_imm = '0;   // r-type and illegal
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_lite_regfile.sv ====
// rv_lite register file
// two async read ports, one sync write port, x0 hard zero
`default_nettype none

module rv_lite_regfile
  import rv_lite_pkg::*;
#(
  parameter int NREGS = 16
) (
  input  logic       clk,
  input  logic [4:0] i_rs1_addr,
  input  logic [4:0] i_rs2_addr,
  output word_t      o_rs1_data,
  output word_t      o_rs2_data,
  input  logic       i_we,
  input  logic [4:0] i_rd_addr,
  input  word_t      i_rd_data
);

  localparam int AW = $clog2(NREGS);

  word_t regs [NREGS];

  // upper address bits dropped when NREGS is 16
  assign o_rs1_data = (i_rs1_addr[AW-1:0] == '0) ? '0 : regs[i_rs1_addr[AW-1:0]];
  assign o_rs2_data = (i_rs2_addr[AW-1:0] == '0) ? '0 : regs[i_rs2_addr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (i_we && (i_rd_addr[AW-1:0] != '0))
      regs[i_rd_addr[AW-1:0]] <= i_rd_data;
  end

endmodule

`default_nettype wire

// ==== rtl/rv_lite_alu.sv ====
// rv_lite alu
// add/sub, logic, shifts, set-less-than and the branch condition
`default_nettype none

module rv_lite_alu
  import rv_lite_pkg::*;
(
  input  alu_op_t    i_alu_op,
  input  logic [2:0] i_funct3_branch,
  input  word_t      i_a,
  input  word_t      i_b,
  output word_t      o_result,
  output logic       o_branch_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;    // signed
  logic       ltu;

  assign shamt = i_b[4:0];
  assign eq    = (i_a == i_b);
  assign lt    = ($signed(i_a) < $signed(i_b));
  assign ltu   = (i_a < i_b);

  always_comb begin
    case (i_alu_op)
      ALU_ADD:   o_result = i_a + i_b;
      ALU_SUB:   o_result = i_a - i_b;
      ALU_SLL:   o_result = i_a << shamt;
      ALU_SLT:   o_result = {{(XLEN-1){1'b0}}, lt};
      ALU_SLTU:  o_result = {{(XLEN-1){1'b0}}, ltu};
      ALU_XOR:   o_result = i_a ^ i_b;
      ALU_SRL:   o_result = i_a >> shamt;
      ALU_SRA:   o_result = word_t'($signed(i_a) >>> shamt);
      ALU_OR:    o_result = i_a | i_b;
      ALU_AND:   o_result = i_a & i_b;
      ALU_PASSB: o_result = i_b;
      default:   o_result = '0;
    endcase
  end

  always_comb begin
    case (i_funct3_branch)
      3'd0:    o_branch_taken = eq;     // beq
      3'd1:    o_branch_taken = !eq;    // bne
      3'd4:    o_branch_taken = lt;     // blt
      3'd5:    o_branch_taken = !lt;    // bge
      3'd6:    o_branch_taken = ltu;    // bltu
      3'd7:    o_branch_taken = !ltu;   // bgeu
      default: o_branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_lite_lsu.sv ====
// rv_lite load/store lane logic
// little-endian store placement and strobes, load lane select and extension
`default_nettype none

module rv_lite_lsu
  import rv_lite_pkg::*;
(
  input  logic [1:0] i_addr_lo,
  input  mem_size_t  i_size,
  input  logic       i_load_unsigned,
  input  word_t      i_store_data,
  output word_t      o_dmem_wdata,
  output logic [3:0] o_dmem_strb,
  input  word_t      i_dmem_rdata,
  output word_t      o_load_data
);

  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  // store, data copied to every lane, strobes pick the ones written
  always_comb begin
    case (i_size)
      MS_BYTE: begin
        o_dmem_wdata = {4{i_store_data[7:0]}};
        o_dmem_strb  = 4'b0001 << i_addr_lo;
      end
      MS_HALF: begin
        o_dmem_wdata = {2{i_store_data[15:0]}};
        o_dmem_strb  = i_addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        o_dmem_wdata = i_store_data;
        o_dmem_strb  = 4'b1111;
      end
    endcase
  end

  // load lane select
  always_comb begin
    case (i_addr_lo)
      2'd0:    rd_byte = i_dmem_rdata[7:0];
      2'd1:    rd_byte = i_dmem_rdata[15:8];
      2'd2:    rd_byte = i_dmem_rdata[23:16];
      default: rd_byte = i_dmem_rdata[31:24];
    endcase
  end

  assign rd_half = i_addr_lo[1] ? i_dmem_rdata[31:16] : i_dmem_rdata[15:0];

  always_comb begin
    case (i_size)
      MS_BYTE: o_load_data = {{24{rd_byte[7] & !i_load_unsigned}}, rd_byte};
      MS_HALF: o_load_data = {{16{rd_half[15] & !i_load_unsigned}}, rd_half};
      default: o_load_data = i_dmem_rdata;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_lite_core.sv ====
// rv_lite core top
// multi-cycle rv32 integer core, control unit wired to the datapath blocks
`default_nettype none

module rv_lite_core
  import rv_lite_pkg::*;
#(
  parameter int    NREGS    = 16,
  parameter word_t RESET_PC = '0
) (
  input  logic       clk,
  input  logic       xreset,
  // instruction bus
  output logic       o_imem_valid,
  output word_t      o_imem_addr,
  input  logic       i_imem_ready,
  input  word_t      i_imem_rdata,
  // data bus
  output logic       o_dmem_valid,
  output logic       o_dmem_we,
  output word_t      o_dmem_addr,
  output word_t      o_dmem_wdata,
  output logic [3:0] o_dmem_strb,
  input  logic       i_dmem_ready,
  input  word_t      i_dmem_rdata
);

  word_t      ir;
  opcode_t    opcode;
  alu_op_t    alu_op;
  mem_size_t  size;
  logic       load_unsigned;
  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  logic [4:0] rd_addr;
  word_t      imm;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  logic       branch_taken;
  word_t      load_data;
  logic       rd_we;
  word_t      rd_data;
  logic [3:0] lsu_strb;

  assign o_dmem_strb = lsu_strb & {4{o_dmem_we}};   // no strobes on reads

  rv_lite_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
    .clk            (clk),            .xreset        (xreset),
    .o_imem_valid   (o_imem_valid),   .o_imem_addr   (o_imem_addr),
    .i_imem_ready   (i_imem_ready),   .i_imem_rdata  (i_imem_rdata),
    .o_dmem_valid   (o_dmem_valid),   .o_dmem_we     (o_dmem_we),
    .o_dmem_addr    (o_dmem_addr),    .i_dmem_ready  (i_dmem_ready),
    .o_ir           (ir),             .i_opcode      (opcode),
    .i_imm          (imm),            .i_rs1_data    (rs1_data),
    .i_rs2_data     (rs2_data),       .i_alu_result  (alu_result),
    .i_branch_taken (branch_taken),   .i_load_data   (load_data),
    .o_alu_a        (alu_a),          .o_alu_b       (alu_b),
    .o_rd_we        (rd_we),          .o_rd_data     (rd_data)
  );

  rv_lite_decode u_decode (
    .i_ir (ir),             .o_opcode (opcode),       .o_alu_op (alu_op),
    .o_size (size),         .o_load_unsigned (load_unsigned),
    .o_rs1_addr (rs1_addr), .o_rs2_addr (rs2_addr),   .o_rd_addr (rd_addr),
    .o_imm (imm)
  );

  rv_lite_regfile #(.NREGS(NREGS)) u_regfile (
    .clk        (clk),
    .i_rs1_addr (rs1_addr), .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data), .o_rs2_data (rs2_data),
    .i_we       (rd_we),    .i_rd_addr  (rd_addr),  .i_rd_data (rd_data)
  );

  rv_lite_alu u_alu (
    .i_alu_op (alu_op), .i_funct3_branch (ir[14:12]),
    .i_a (alu_a),       .i_b (alu_b),
    .o_result (alu_result), .o_branch_taken (branch_taken)
  );

  rv_lite_lsu u_lsu (
    .i_addr_lo    (alu_result[1:0]), .i_size       (size),
    .i_load_unsigned (load_unsigned), .i_store_data (rs2_data),
    .o_dmem_wdata (o_dmem_wdata),    .o_dmem_strb  (lsu_strb),
    .i_dmem_rdata (i_dmem_rdata),    .o_load_data  (load_data)
  );

endmodule

`default_nettype wire

// ==== tb/rv_lite_sva.sv ====
// rv_lite bus protocol assertions
// valid/ready hold rules on both buses, one request at a time
`default_nettype none

module rv_lite_sva
  import rv_lite_pkg::*;
(
  input wire logic       clk,
  input wire logic       xreset,
  input wire logic       o_imem_valid,
  input wire word_t      o_imem_addr,
  input wire logic       i_imem_ready,
  input wire logic       o_dmem_valid,
  input wire logic       o_dmem_we,
  input wire word_t      o_dmem_addr,
  input wire logic [3:0] o_dmem_strb,
  input wire logic       i_dmem_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  a_imem_hold: assert property (@(posedge clk) disable iff (!xreset)
    o_imem_valid && !i_imem_ready |=> o_imem_valid && $stable(o_imem_addr))
    else $error("imem request dropped or moved before ready");

  a_dmem_hold: assert property (@(posedge clk) disable iff (!xreset)
    o_dmem_valid && !i_dmem_ready |=> o_dmem_valid && $stable(o_dmem_addr))
    else $error("dmem request dropped or moved before ready");

  a_one_bus: assert property (@(posedge clk) disable iff (!xreset)
    !(o_imem_valid && o_dmem_valid))
    else $error("both bus requests high together");

  a_read_strb: assert property (@(posedge clk) disable iff (!xreset)
    o_dmem_valid && !o_dmem_we |-> o_dmem_strb == 4'b0000)
    else $error("strobes set on a read");

endmodule

bind rv_lite_core rv_lite_sva u_sva (.*);

`default_nettype wire

// ==== tb/rv_lite_tb.sv ====
// rv_lite testbench
// random-ready bus models, assembled program, isa reference model and write checks
`default_nettype none

module rv_lite_tb
  import rv_lite_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    MEM_WORDS = 256;
  localparam word_t MARKER    = 32'h0000_03fc;
  localparam word_t START_PC  = 32'h0000_0040;
  localparam int    TIMEOUT   = 20000;

  logic clk = 1'b0;
  logic xreset;
  logic imem_valid, imem_ready, dmem_valid, dmem_we, dmem_ready;
  word_t imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic [3:0] dmem_strb;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  word_t exp_addr[$];
  word_t exp_data[$];
  logic [3:0] exp_strb[$];
  int prog_idx, wr_idx, checks, errors, tests;
  logic done, fetched;

  rv_lite_core #(.NREGS(16), .RESET_PC(START_PC)) dut0 (
    .clk(clk), .xreset(xreset),
    .o_imem_valid(imem_valid), .o_imem_addr(imem_addr),
    .i_imem_ready(imem_ready), .i_imem_rdata(imem_rdata),
    .o_dmem_valid(dmem_valid), .o_dmem_we(dmem_we), .o_dmem_addr(dmem_addr),
    .o_dmem_wdata(dmem_wdata), .o_dmem_strb(dmem_strb),
    .i_dmem_ready(dmem_ready), .i_dmem_rdata(dmem_rdata)
  );

  always #20 clk = ~clk;

  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // ready patterns for both buses
  initial begin
    imem_ready = 1'b0;
    dmem_ready = 1'b0;
    void'($urandom(32'h1195));
    forever begin
      @(negedge clk);
      imem_ready <= ($urandom % 2) == 0;   // back-pressure, 1 in 2
      dmem_ready <= ($urandom % 2) == 0;
    end
  end

  always @(posedge clk) begin
    if (dmem_valid && dmem_ready && dmem_we)
      for (int k = 0; k < 4; k++)
        if (dmem_strb[k])
          dmem[dmem_addr[9:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
  end

  function automatic word_t fill(int i);
    return (i + 1) * 32'h9e37_79b9;   // differs for every address
  endfunction

  function automatic word_t strb_mask(logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  task automatic check(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // instruction encoders
  function automatic word_t r_ins(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction
  function automatic word_t i_ins(word_t imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
  endfunction
  function automatic word_t s_ins(word_t imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'h23};
  endfunction
  function automatic word_t b_ins(word_t imm, int rs1, int rs2, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'h63};
  endfunction
  function automatic word_t u_ins(logic [19:0] imm, int rd, logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction
  function automatic word_t j_ins(word_t imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
  endfunction

  task automatic emit(word_t w);
    imem[prog_idx] = w;
    prog_idx++;
  endtask

  task automatic build_program();
    emit(i_ins(256, 0, 0, 15, 7'h13));       // x15 = data base
    emit(u_ins(20'h12345, 1, 7'h37));
    emit(i_ins(32'h678, 1, 0, 1, 7'h13));
    emit(s_ins(0, 1, 15, 2));
    emit(i_ins(-5, 0, 0, 2, 7'h13));
    emit(r_ins(0, 1, 2, 2, 3));              // slt
    emit(r_ins(0, 1, 2, 3, 4));              // sltu
    emit(s_ins(4, 3, 15, 2));
    emit(s_ins(8, 4, 15, 2));
    emit(i_ins(32'h401, 2, 5, 5, 7'h13));    // srai 1
    emit(i_ins(28, 2, 5, 6, 7'h13));         // srli 28
    emit(r_ins(0, 6, 1, 1, 7));              // sll
    emit(r_ins(7'h20, 2, 1, 0, 8));          // sub
    emit(r_ins(0, 8, 7, 4, 9));              // xor
    emit(s_ins(12, 5, 15, 2));
    emit(s_ins(16, 6, 15, 2));
    emit(s_ins(20, 9, 15, 2));
    emit(i_ins(77, 0, 0, 0, 7'h13));         // x0 stays zero
    emit(s_ins(24, 0, 15, 2));
    emit(u_ins(20'h00001, 10, 7'h17));       // auipc
    emit(s_ins(28, 10, 15, 2));
    emit(s_ins(32, 1, 15, 0));               // sb
    emit(s_ins(38, 1, 15, 1));               // sh upper half
    emit(s_ins(40, 2, 15, 2));
    emit(i_ins(40, 15, 0, 11, 7'h03));       // lb
    emit(i_ins(41, 15, 4, 12, 7'h03));       // lbu
    emit(i_ins(42, 15, 1, 13, 7'h03));       // lh
    emit(i_ins(2, 15, 5, 14, 7'h03));        // lhu
    emit(s_ins(44, 11, 15, 2));
    emit(s_ins(48, 12, 15, 2));
    emit(s_ins(52, 13, 15, 2));
    emit(s_ins(56, 14, 15, 2));
    emit(i_ins(128, 15, 2, 3, 7'h03));       // lw from fill
    emit(s_ins(60, 3, 15, 2));
    emit(b_ins(8, 3, 3, 0));                 // beq taken
    emit(i_ins(1, 0, 0, 4, 7'h13));
    emit(b_ins(8, 0, 0, 1));                 // bne not taken
    emit(i_ins(2, 4, 0, 4, 7'h13));
    emit(b_ins(8, 2, 0, 4));                 // blt taken
    emit(i_ins(16, 4, 0, 4, 7'h13));
    emit(b_ins(8, 2, 1, 7));                 // bgeu taken
    emit(i_ins(32, 4, 0, 4, 7'h13));
    emit(b_ins(8, 2, 1, 6));                 // bltu not taken
    emit(i_ins(4, 4, 0, 4, 7'h13));
    emit(b_ins(8, 0, 2, 5));                 // bge taken
    emit(i_ins(64, 4, 0, 4, 7'h13));
    emit(s_ins(64, 4, 15, 2));
    emit(j_ins(12, 5));                      // jal, link in x5
    emit(i_ins(99, 0, 0, 4, 7'h13));
    emit(i_ins(98, 0, 0, 4, 7'h13));
    emit(s_ins(68, 5, 15, 2));
    emit(i_ins(START_PC + 220, 0, 0, 6, 7'h13));
    emit(i_ins(1, 6, 0, 7, 7'h67));          // jalr, low bit dropped
    emit(i_ins(97, 0, 0, 4, 7'h13));
    emit(i_ins(96, 0, 0, 4, 7'h13));
    emit(s_ins(72, 7, 15, 2));
    emit(32'h0000_0000);                     // illegal, steps over
    emit(i_ins(1020, 0, 0, 1, 7'h13));
    emit(s_ins(0, 4, 1, 2));                 // marker store
    emit(j_ins(0, 0));
  endtask

  // isa model of the kept subset, fills the expected write queues
  function automatic void run_model();
    word_t r [16];
    word_t m [MEM_WORDS];
    word_t pc, ins, a, b, res, ea, w;
    logic [3:0] st;
    logic [4:0] rd;
    logic [2:0] f3;
    logic stop;
    pc = START_PC;
    stop = 1'b0;
    for (int i = 0; i < 16; i++)
      r[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      m[i] = fill(i);
    for (int step = 0; step < 2000 && !stop; step++) begin
      ins = imem[pc[9:2]];
      rd  = ins[11:7];
      f3  = ins[14:12];
      a   = r[ins[18:15]];
      b   = r[ins[23:20]];
      res = '0;
      case (ins[6:0])
        7'h33, 7'h13: begin
          if (ins[6:0] == 7'h13)
            b = {{20{ins[31]}}, ins[31:20]};
          case (f3)
            0: res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
            1: res = a << b[4:0];
            2: res = word_t'($signed(a) < $signed(b));
            3: res = word_t'(a < b);
            4: res = a ^ b;
            5: res = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: res = a | b;
            default: res = a & b;
          endcase
          pc += 4;
        end
        7'h37: begin res = {ins[31:12], 12'h0}; pc += 4; end
        7'h17: begin res = pc + {ins[31:12], 12'h0}; pc += 4; end
        7'h6f: begin
          res = pc + 4;
          pc += {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h67: begin
          res = pc + 4;
          pc = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'h1;
        end
        7'h63: begin
          case (f3)
            0: stop = (a == b);
            1: stop = (a != b);
            4: stop = $signed(a) < $signed(b);
            5: stop = $signed(a) >= $signed(b);
            6: stop = a < b;
            default: stop = a >= b;
          endcase
          pc += stop ? {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0} : 4;
          stop = 1'b0;
        end
        7'h03: begin
          ea = a + {{20{ins[31]}}, ins[31:20]};
          w = m[ea[9:2]] >> (8 * ea[1:0]);
          case (f3)
            0: res = {{24{w[7]}}, w[7:0]};
            1: res = {{16{w[15]}}, w[15:0]};
            4: res = {24'h0, w[7:0]};
            5: res = {16'h0, w[15:0]};
            default: res = w;
          endcase
          pc += 4;
        end
        7'h23: begin
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          st = (f3[1:0] == 0) ? 4'b0001 << ea[1:0] :
               (f3[1:0] == 1) ? 4'b0011 << ea[1:0] : 4'b1111;
          w = b << (8 * ea[1:0]);
          for (int k = 0; k < 4; k++)
            if (st[k])
              m[ea[9:2]][8*k +: 8] = w[8*k +: 8];
          exp_addr.push_back(ea);
          exp_strb.push_back(st);
          exp_data.push_back(w & strb_mask(st));
          stop = (ea == MARKER);
          pc += 4;
        end
        default: pc += 4;
      endcase
      if (ins[6:0] inside {7'h33, 7'h13, 7'h37, 7'h17, 7'h6f, 7'h67, 7'h03} && rd[3:0] != 0)
        r[rd[3:0]] = res;
    end
  endfunction

  // compares every data write handshake with the model
  always @(posedge clk) begin
    if (xreset && dmem_valid && !fetched) begin
      errors++;
      $display("** Error data request before the first instruction fetch");
    end
    if (imem_valid && imem_ready)
      fetched <= 1'b1;
    if (xreset && dmem_valid && dmem_ready && dmem_we) begin
      if (wr_idx < exp_addr.size()) begin
        check("o_dmem_addr", dmem_addr, exp_addr[wr_idx]);
        check("o_dmem_strb", word_t'(dmem_strb), word_t'(exp_strb[wr_idx]));
        check("o_dmem_wdata", dmem_wdata & strb_mask(dmem_strb), exp_data[wr_idx]);
      end else begin
        errors++;
        $display("** Error data write beyond the end of the expected sequence");
      end
      wr_idx <= wr_idx + 1;
      if (dmem_addr == MARKER)
        done <= 1'b1;
    end
  end

  task automatic give_up(string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  initial begin
    int n;
    xreset = 1'b0;
    done = 1'b0;
    fetched = 1'b0;
    {prog_idx, wr_idx, checks, errors, tests} = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0;
      dmem[i] = fill(i);
    end
    prog_idx = int'(START_PC[9:2]);   // program starts at the reset pc
    build_program();
    run_model();
    repeat (16) begin
      @(negedge clk);
      check("o_imem_valid", word_t'(imem_valid), 0);
      check("o_dmem_valid", word_t'(dmem_valid), 0);
    end
    xreset = 1'b1;
    @(posedge clk);
    check("o_imem_valid", word_t'(imem_valid), 0);   // first cycle out of reset
    n = 0;
    while (!imem_valid) begin
      @(posedge clk);
      n++;
      if (n > 100)
        give_up("the first instruction request");
    end
    check("o_imem_addr", imem_addr, START_PC);
    tests++;
    $display("test reset and first fetch done, errors %0d", errors);
    n = 0;
    while (!done) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        give_up("the marker store");
    end
    @(negedge clk);
    check("write count", wr_idx, exp_addr.size());
    tests++;
    $display("test program write sequence done, %0d writes, errors %0d", wr_idx, errors);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_lite.f ====
rtl/rv_lite_pkg.sv
rtl/rv_lite_ctrl.sv
rtl/rv_lite_decode.sv
rtl/rv_lite_regfile.sv
rtl/rv_lite_alu.sv
rtl/rv_lite_lsu.sv
rtl/rv_lite_core.sv
tb/rv_lite_sva.sv
tb/rv_lite_tb.sv
